//--- source/lsu_config.svh
// LSU memory sizing, shared by the aligner, the banks and the top level
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

//////////////////////
// Data memory size
//////////////////////

// Number of 32-bit words in the local data memory
// Byte addresses at or above 4 * LSU_DEPTH_WORDS raise an access fault
`define LSU_DEPTH_WORDS 256

// Width of the word index into one byte-lane bank
// Must cover LSU_DEPTH_WORDS entries
`define LSU_INDEX_W 8

`endif

//--- source/lsu_pkg.sv
// LSU types: access size, exception cause and the byte/halfword view of a lane word
package lsu_pkg;

    //////////////////////
    // Access size
    //////////////////////

    // Encoded as the RV32 funct3 of loads and stores
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,  // Byte, sign-extended on load
        SZ_H  = 3'b001,  // Halfword, sign-extended on load
        SZ_W  = 3'b010,  // Word
        SZ_BU = 3'b100,  // Byte, zero-extended; store treats as SZ_B
        SZ_HU = 3'b101   // Halfword, zero-extended; store treats as SZ_H
    } mem_size_e;

    //////////////////////
    // Exception cause
    //////////////////////

    // RISC-V mcause codes for the data side
    typedef enum logic [3:0] {
        EXC_NONE        = 4'd0,  // No memory exception
        EXC_LD_MISALIGN = 4'd4,  // Load address misaligned
        EXC_LD_FAULT    = 4'd5,  // Load access fault
        EXC_ST_MISALIGN = 4'd6,  // Store address misaligned
        EXC_ST_FAULT    = 4'd7   // Store access fault
    } exc_cause_e;

    // One data word decoded as lanes
    // b[0] is the byte at address offset 0, h[0] the lower halfword
    typedef union packed {
        logic [3:0][7:0]  b;  // Byte lanes
        logic [1:0][15:0] h;  // Halfword lanes
    } lane_word_u;

endpackage

//--- source/store_align.sv
// Store aligner: checks each request, drives the byte-lane banks and loads the stage-1 register
`timescale 1ns/10ps
`include "lsu_config.svh"

module store_align
    import lsu_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    stall_i,          // Holds stage 1, blocks bank access
    // Request from execute
    input  logic                    req_valid_i,
    input  logic                    req_load_i,
    input  logic                    req_store_i,
    input  mem_size_e               req_size_i,
    input  logic [31:0]             req_addr_i,       // Address, or ALU result for non-memory ops
    input  logic [31:0]             req_wdata_i,
    input  logic [4:0]              req_rd_i,
    input  logic                    req_reg_write_i,
    // Bank side
    output logic                    bank_en_o,
    output logic [3:0]              lane_we_o,
    output lane_word_u              lane_wdata_o,
    output logic [`LSU_INDEX_W-1:0] bank_index_o,
    // Stage-1 register
    output logic                    s1_valid_o,
    output logic                    s1_load_o,
    output mem_size_e               s1_size_o,
    output logic [1:0]              s1_lsb_o,
    output logic [31:0]             s1_result_o,
    output logic [4:0]              s1_rd_o,
    output logic                    s1_reg_write_o,
    output logic                    s1_exc_valid_o,
    output exc_cause_e              s1_exc_cause_o
);

    logic       accept;      // Request taken on this edge
    logic       mem_access;  // Load or store
    logic       misalign;    // Halfword or word off its boundary
    logic       fault;       // Beyond the local memory
    logic       exc;
    logic [3:0] byte_mask;   // Lanes touched by the access
    exc_cause_e cause;

    assign accept     = req_valid_i && !stall_i;
    assign mem_access = req_load_i || req_store_i;
    assign fault      = req_addr_i[31:2] >= 30'(`LSU_DEPTH_WORDS);
    assign exc        = mem_access && (misalign || fault);

    //////////////////////
    // Size decode
    //////////////////////

    always_comb begin
        misalign  = 1'b0;
        byte_mask = 4'b0000;  // Undefined sizes touch no lane
        case (req_size_i)
            SZ_B, SZ_BU: byte_mask = 4'b0001 << req_addr_i[1:0];
            SZ_H, SZ_HU: begin
                misalign  = req_addr_i[0];
                byte_mask = 4'b0011 << req_addr_i[1:0];
            end
            SZ_W: begin
                misalign  = |req_addr_i[1:0];
                byte_mask = 4'b1111;
            end
            default: ;
        endcase
    end

    // Misaligned beats fault
    always_comb begin
        cause = EXC_NONE;
        if (mem_access && misalign) begin
            cause = req_load_i ? EXC_LD_MISALIGN : EXC_ST_MISALIGN;
        end else if (mem_access && fault) begin
            cause = req_load_i ? EXC_LD_FAULT : EXC_ST_FAULT;
        end
    end

    // Replicate store data so every lane sees its own slice
    always_comb begin
        case (req_size_i)
            SZ_B, SZ_BU: lane_wdata_o.b = {4{req_wdata_i[7:0]}};
            SZ_H, SZ_HU: lane_wdata_o.h = {2{req_wdata_i[15:0]}};
            default:     lane_wdata_o.b = req_wdata_i;
        endcase
    end

    assign bank_en_o    = accept && mem_access && !exc;           // Clean accesses only
    assign lane_we_o    = (bank_en_o && req_store_i) ? byte_mask : 4'b0000;
    assign bank_index_o = req_addr_i[`LSU_INDEX_W+1:2];           // Word index

    //////////////////////
    // Stage-1 register
    //////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_o     <= 1'b0;
            s1_load_o      <= 1'b0;
            s1_reg_write_o <= 1'b0;
            s1_exc_valid_o <= 1'b0;
        end else if (!stall_i) begin
            s1_valid_o     <= req_valid_i;  // Bubble when nothing is offered
            s1_load_o      <= req_valid_i && req_load_i;
            s1_reg_write_o <= req_valid_i && req_reg_write_i;
            s1_exc_valid_o <= req_valid_i && exc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            s1_size_o      <= req_size_i;
            s1_lsb_o       <= req_addr_i[1:0];
            s1_result_o    <= req_addr_i;   // Also the tval on an exception
            s1_rd_o        <= req_rd_i;
            s1_exc_cause_o <= cause;
        end
    end

    // Execute never issues a combined load and store
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> !(req_load_i && req_store_i));

    // Lane writes only with the bank enabled, as one aligned byte, half or word
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|lane_we_o) |-> (bank_en_o && (lane_we_o inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                          4'b0011, 4'b1100, 4'b1111})));

endmodule

//--- source/byte_bank.sv
// Byte bank: one lane of the data memory, synchronous and read-first
`timescale 1ns/10ps
`include "lsu_config.svh"

module byte_bank (
    input  logic                    clk_i,
    input  logic                    en_i,     // Read, and write when we_i
    input  logic                    we_i,
    input  logic [`LSU_INDEX_W-1:0] index_i,  // Word index
    input  logic [7:0]              wdata_i,
    output logic [7:0]              rdata_o   // Holds while en_i is low
);

    logic [7:0] mem_q [`LSU_DEPTH_WORDS];

    // Old data comes out on a write to the same entry
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= mem_q[index_i];
            if (we_i) begin
                mem_q[index_i] <= wdata_i;
            end
        end
    end

endmodule

//--- source/load_align.sv
// Load aligner: extends load data, picks the write-back value and holds the MEM/WB register
`timescale 1ns/10ps

module load_align
    import lsu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        stall_i,         // Holds MEM/WB
    // Stage-1 register
    input  logic        s1_valid_i,
    input  logic        s1_load_i,
    input  mem_size_e   s1_size_i,
    input  logic [1:0]  s1_lsb_i,        // Byte offset in the word
    input  logic [31:0] s1_result_i,
    input  logic [4:0]  s1_rd_i,
    input  logic        s1_reg_write_i,
    input  logic        s1_exc_valid_i,
    input  exc_cause_e  s1_exc_cause_i,
    // Bank read data
    input  lane_word_u  lane_rdata_i,
    // Write-back
    output logic        wb_valid_o,
    output logic        wb_reg_write_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o,
    // Exception record
    output logic        exc_valid_o,
    output exc_cause_e  exc_cause_o,
    output logic [31:0] exc_tval_o       // Faulting address
);

    logic [31:0] load_data;  // Extended load value
    logic [31:0] wb_data_d;
    logic        reg_write_d;

    //////////////////////
    // Extraction
    //////////////////////

    always_comb begin
        logic [7:0]  byte_sel;
        logic [15:0] half_sel;

        byte_sel = lane_rdata_i.b[s1_lsb_i];     // Any offset
        half_sel = lane_rdata_i.h[s1_lsb_i[1]];  // Aligned halves only reach here
        case (s1_size_i)
            SZ_B:    load_data = {{24{byte_sel[7]}}, byte_sel};
            SZ_H:    load_data = {{16{half_sel[15]}}, half_sel};
            SZ_BU:   load_data = {24'b0, byte_sel};
            SZ_HU:   load_data = {16'b0, half_sel};
            default: load_data = lane_rdata_i.b;  // Full word
        endcase
    end

    assign wb_data_d   = s1_load_i ? load_data : s1_result_i;
    assign reg_write_d = s1_valid_i && s1_reg_write_i && !s1_exc_valid_i;  // No write on a trap

    //////////////////////
    // MEM/WB register
    //////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_valid_o     <= 1'b0;
            wb_reg_write_o <= 1'b0;
            exc_valid_o    <= 1'b0;
        end else if (!stall_i) begin
            wb_valid_o     <= s1_valid_i;
            wb_reg_write_o <= reg_write_d;
            exc_valid_o    <= s1_valid_i && s1_exc_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            wb_rd_o     <= s1_rd_i;
            wb_data_o   <= wb_data_d;
            exc_cause_o <= s1_exc_cause_i;
            exc_tval_o  <= s1_result_i;   // Address of the failing access
        end
    end

    // A trapping item never writes the register file and carries a data-side cause
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        exc_valid_o |-> (!wb_reg_write_o && (exc_cause_o inside {EXC_LD_MISALIGN, EXC_LD_FAULT,
                                                                 EXC_ST_MISALIGN, EXC_ST_FAULT})));

endmodule

//--- source/lsu_top.sv
// LSU top: store aligner, four byte-lane banks and load aligner in a two-stage slice
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        stall_i,
    // Request
    input  logic        req_valid_i,
    input  logic        req_load_i,
    input  logic        req_store_i,
    input  mem_size_e   req_size_i,
    input  logic [31:0] req_addr_i,
    input  logic [31:0] req_wdata_i,
    input  logic [4:0]  req_rd_i,
    input  logic        req_reg_write_i,
    // Write-back and exception
    output logic        wb_valid_o,
    output logic        wb_reg_write_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o,
    output logic        exc_valid_o,
    output exc_cause_e  exc_cause_o,
    output logic [31:0] exc_tval_o
);

    // Aligner to banks
    logic                    bank_en;
    logic [3:0]              lane_we;
    lane_word_u              lane_wdata;
    logic [`LSU_INDEX_W-1:0] bank_index;
    logic [7:0]              bank_rdata [4];  // One byte per lane
    lane_word_u              lane_rdata;

    // Stage 1 to load aligner
    logic        s1_valid;
    logic        s1_load;
    mem_size_e   s1_size;
    logic [1:0]  s1_lsb;
    logic [31:0] s1_result;
    logic [4:0]  s1_rd;
    logic        s1_reg_write;
    logic        s1_exc_valid;
    exc_cause_e  s1_exc_cause;

    store_align u_store_align (
        .clk_i, .rst_ni, .stall_i,
        .req_valid_i, .req_load_i, .req_store_i, .req_size_i,
        .req_addr_i, .req_wdata_i, .req_rd_i, .req_reg_write_i,
        .bank_en_o      (bank_en),
        .lane_we_o      (lane_we),
        .lane_wdata_o   (lane_wdata),
        .bank_index_o   (bank_index),
        .s1_valid_o     (s1_valid),
        .s1_load_o      (s1_load),
        .s1_size_o      (s1_size),
        .s1_lsb_o       (s1_lsb),
        .s1_result_o    (s1_result),
        .s1_rd_o        (s1_rd),
        .s1_reg_write_o (s1_reg_write),
        .s1_exc_valid_o (s1_exc_valid),
        .s1_exc_cause_o (s1_exc_cause)
    );

    //////////////////////
    // Byte-lane banks
    //////////////////////

    for (genvar g = 0; g < 4; g++) begin : g_lane
        byte_bank u_bank (
            .clk_i,
            .en_i    (bank_en),      // All lanes read together
            .we_i    (lane_we[g]),
            .index_i (bank_index),
            .wdata_i (lane_wdata.b[g]),
            .rdata_o (bank_rdata[g])
        );
    end

    // Lane 0 holds the lowest byte address
    assign lane_rdata.b = {bank_rdata[3], bank_rdata[2], bank_rdata[1], bank_rdata[0]};

    load_align u_load_align (
        .clk_i, .rst_ni, .stall_i,
        .s1_valid_i     (s1_valid),
        .s1_load_i      (s1_load),
        .s1_size_i      (s1_size),
        .s1_lsb_i       (s1_lsb),
        .s1_result_i    (s1_result),
        .s1_rd_i        (s1_rd),
        .s1_reg_write_i (s1_reg_write),
        .s1_exc_valid_i (s1_exc_valid),
        .s1_exc_cause_i (s1_exc_cause),
        .lane_rdata_i   (lane_rdata),
        .wb_valid_o, .wb_reg_write_o, .wb_rd_o, .wb_data_o,
        .exc_valid_o, .exc_cause_o, .exc_tval_o
    );

endmodule

//--- bench/tb_lsu.sv
// LSU testbench: reference memory model, directed and random traffic, in-order result check
`timescale 1ns/10ps
`include "lsu_config.svh"

module tb_lsu
    import lsu_pkg::*;
;

    localparam int N_RAND  = 300;                                // Random items per random phase
    localparam int N_REQ   = 256 + 2 + 46 + 30 + 8 + 2 * N_RAND; // Requests over all phases
    localparam int MAX_CYC = 4 * N_REQ + 50;

    typedef struct packed {
        logic        rw;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        exc;
        logic [3:0]  cause;
        logic [31:0] tval;
    } exp_t;

    logic        clk_i, rst_ni, stall_i;
    logic        req_valid_i, req_load_i, req_store_i, req_reg_write_i;
    mem_size_e   req_size_i;
    logic [31:0] req_addr_i, req_wdata_i;
    logic [4:0]  req_rd_i;
    logic        wb_valid_o, wb_reg_write_o, exc_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o, exc_tval_o;
    exc_cause_e  exc_cause_o;

    logic [7:0]  model [4 * `LSU_DEPTH_WORDS];  // Byte-addressed reference memory
    exp_t        exp_q [$];                     // Predicted records, in issue order
    int          acc_edges [$];                 // Advancing-edge number of each accept
    logic [31:0] rand_state = 32'd19675;
    mem_size_e   size_tab [5] = '{SZ_B, SZ_H, SZ_W, SZ_BU, SZ_HU};
    string       test_name = "reset";
    logic        stall_en = 1'b0;
    int          n_val = 0, n_other = 0, edge_cnt = 0, cycles = 0;
    logic        adv_q = 1'b0, acc_q = 1'b0, stalled_q = 1'b0;
    logic [75:0] snap;                          // Outputs after the previous edge

    lsu_top lsu_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        rand_state ^= rand_state << 13;  // xorshift32
        rand_state ^= rand_state >> 17;
        rand_state ^= rand_state << 5;
        return rand_state;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    // Expected record at issue time; only clean stores touch the model
    function automatic exp_t predict(input logic ld, input logic st, input logic [2:0] sz,
                                     input logic [31:0] addr, input logic [31:0] wdata,
                                     input logic [4:0] rd, input logic rw);
        exp_t e;
        int   nb;
        logic mis;
        logic flt;
        nb  = (sz[1:0] == 2'b00) ? 1 : (sz[1:0] == 2'b01) ? 2 : 4;
        mis = (ld || st) && ((nb == 2 && addr[0]) || (nb == 4 && addr[1:0] != 2'b00));
        flt = (ld || st) && (addr >= 4 * `LSU_DEPTH_WORDS);
        e.exc   = mis || flt;
        e.cause = mis ? (ld ? 4'd4 : 4'd6) : flt ? (ld ? 4'd5 : 4'd7) : 4'd0;  // Misaligned first
        e.tval  = addr;
        e.rd    = rd;
        e.rw    = rw && !e.exc;
        e.data  = addr;                          // Stores and ALU ops pass the address through
        if (ld && !e.exc) begin
            e.data = '0;
            for (int i = 0; i < nb; i++) e.data[8*i +: 8] = model[addr[9:0] + i];
            if (!sz[2] && nb == 1) e.data = {{24{e.data[7]}}, e.data[7:0]};
            if (!sz[2] && nb == 2) e.data = {{16{e.data[15]}}, e.data[15:0]};
        end
        if (st && !e.exc) begin
            for (int i = 0; i < nb; i++) model[addr[9:0] + i] = wdata[8*i +: 8];
        end
        return e;
    endfunction

    // Offer one request and hold it through random stalls until accepted
    task automatic issue(input logic ld, input logic st, input mem_size_e sz,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [4:0] rd, input logic rw);
        logic [31:0] r;
        req_load_i      = ld;
        req_store_i     = st;
        req_size_i      = sz;
        req_addr_i      = addr;
        req_wdata_i     = wdata;
        req_rd_i        = rd;
        req_reg_write_i = rw;
        req_valid_i     = 1'b1;
        exp_q.push_back(predict(ld, st, sz, addr, wdata, rd, rw));
        do begin
            r       = next_rand();
            stall_i = stall_en && (r[1:0] == 2'b00);
            @(posedge clk_i);
            #10;
        end while (stall_i);
        req_valid_i = 1'b0;
    endtask

    task automatic idle();
        req_valid_i = 1'b0;
        stall_i     = 1'b0;
        @(posedge clk_i);
        #10;
    endtask

    // Every size at every offset of one word, misaligned ones included
    task automatic load_all(input logic [31:0] base);
        foreach (size_tab[s]) begin
            for (int off = 0; off < 4; off++) begin
                issue(1, 0, size_tab[s], base + off, '0, 5'(off + 1), 1);
            end
        end
    endtask

    task automatic random_traffic(input int n);
        logic [31:0] r;
        logic [31:0] addr;
        for (int k = 0; k < n; k++) begin
            r = next_rand();
            if (r[31:29] == 3'd0) idle();                           // Occasional bubble
            addr = (r[28:26] == 3'd0) ? next_rand() : (next_rand() & 32'h3ff);
            issue(r[4:3] == 2'd1 || r[4:3] == 2'd2, r[4:3] == 2'd3,  // 0 ALU, 1-2 load, 3 store
                  size_tab[r[15:13] % 5], addr, next_rand(), r[9:5], r[10]);
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("error %s %s expected %h actual %h", test_name, what, exp, act);
            n_val++;
        end
    endtask

    ////////////////////
    // Compare
    ////////////////////

    always @(posedge clk_i) begin
        adv_q     = rst_ni && !stall_i;  // Edge that moves the pipeline
        acc_q     = adv_q && req_valid_i;
        stalled_q = rst_ni && stall_i;
    end

    always @(negedge clk_i) begin : compare
        exp_t        e;
        int          a;
        logic [75:0] cur;
        cur = {wb_valid_o, wb_reg_write_o, wb_rd_o, wb_data_o,
               exc_valid_o, exc_cause_o, exc_tval_o};
        if (adv_q) begin
            edge_cnt++;
            if (acc_q) acc_edges.push_back(edge_cnt);
            if (wb_valid_o) begin
                assert (exp_q.size() != 0 && acc_edges.size() != 0) else begin
                    $display("Write-back seen with no request outstanding in %s", test_name);
                    n_other++;
                end
                if (exp_q.size() != 0 && acc_edges.size() != 0) begin
                    e = exp_q.pop_front();
                    a = acc_edges.pop_front();
                    // Shown one advancing edge after accept, taken by write-back on the next
                    assert (edge_cnt - a == 1) else begin
                        $display("Result in %s came %0d edges after accept", test_name,
                                 edge_cnt - a);
                        n_other++;
                    end
                    check_val("rd", e.rd, wb_rd_o);
                    check_val("reg_write", e.rw, wb_reg_write_o);
                    check_val("exc_valid", e.exc, exc_valid_o);
                    if (e.exc) begin
                        check_val("cause", e.cause, exc_cause_o);
                        check_val("tval", e.tval, exc_tval_o);
                    end else begin
                        check_val("data", e.data, wb_data_o);
                    end
                end
            end
        end else if (stalled_q) begin
            assert (cur === snap) else begin
                $display("Outputs changed during a stall in %s", test_name);
                n_other++;
            end
        end
        snap = cur;
    end

    // Bounded run length
    initial begin
        @(posedge rst_ni);
        while (cycles < MAX_CYC) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout after %0d cycles in %s with %0d results missing", cycles, test_name,
                 exp_q.size());
        $display("Errors: %0d value, %0d other", n_val, n_other);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        {rst_ni, stall_i, req_valid_i, req_load_i, req_store_i, req_reg_write_i} = '0;
        req_size_i  = SZ_W;
        req_addr_i  = 32'h0;
        req_wdata_i = 32'h0;
        req_rd_i    = 5'h0;
        repeat (3) @(posedge clk_i);
        #10 rst_ni = 1'b1;

        test_name = "fill";                          // Every word defined before any load
        for (int i = 0; i < `LSU_DEPTH_WORDS; i++)
            issue(0, 1, SZ_W, 4 * i, i * 32'h0101_0193 ^ 32'hc3a5_0f1e, 5'd0, 0);
        test_name = "word_rw";
        issue(0, 1, SZ_W, 32'h40, next_rand(), 5'd3, 0);
        issue(1, 0, SZ_W, 32'h40, '0, 5'd4, 1);
        test_name = "sub_word";
        for (int off = 0; off < 4; off++) issue(0, 1, SZ_B, 32'h80 + off, next_rand(), 5'd0, 0);
        load_all(32'h80);
        issue(0, 1, SZ_H, 32'h90, next_rand(), 5'd0, 0);
        issue(0, 1, SZ_HU, 32'h92, 32'h0000_8f01, 5'd0, 0);  // Sign bit set in the upper half
        load_all(32'h90);
        test_name = "misalign";
        for (int off = 1; off < 4; off++) begin
            if (off[0]) begin
                issue(0, 1, SZ_H, 32'hc0 + off, next_rand(), 5'd5, 1);
                issue(1, 0, SZ_HU, 32'hc0 + off, '0, 5'd6, 1);
            end
            issue(0, 1, SZ_W, 32'hc0 + off, next_rand(), 5'd7, 1);
            issue(1, 0, SZ_W, 32'hc0 + off, '0, 5'd8, 1);
        end
        load_all(32'hc0);                            // Word left as filled
        test_name = "fault";
        issue(1, 0, SZ_W, 32'h400, '0, 5'd9, 1);
        issue(0, 1, SZ_W, 32'h400, next_rand(), 5'd9, 1);
        issue(1, 0, SZ_BU, 32'h8000_0003, '0, 5'd10, 1);
        issue(0, 1, SZ_B, 32'h7ff, next_rand(), 5'd10, 1);
        issue(1, 0, SZ_H, 32'h401, '0, 5'd11, 1);    // Both apply, misaligned reported
        issue(0, 1, SZ_W, 32'h402, next_rand(), 5'd11, 1);
        issue(1, 0, SZ_W, 32'h3fc, '0, 5'd12, 1);    // Last legal word
        issue(0, 0, SZ_W, 32'hffff_fff0, '0, 5'd13, 1);
        test_name = "random";
        random_traffic(N_RAND);
        test_name = "random_stall";
        stall_en  = 1'b1;
        random_traffic(N_RAND);
        stall_en  = 1'b0;
        while (exp_q.size() != 0) idle();             // Drain, timeout catches lost items

        $display("Errors: %0d value, %0d other", n_val, n_other);
        if (n_val + n_other == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+source
source/lsu_pkg.sv
source/store_align.sv
source/byte_bank.sv
source/load_align.sv
source/lsu_top.sv
bench/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu_slice

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/store_align.sv
      - source/byte_bank.sv
      - source/load_align.sv
      - source/lsu_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/tb_lsu.sv
